/* source/btac_pkg.sv */
package btac_pkg;

  // Buffer geometry. Bit 0 of the PC is never used, so the index starts at bit 1.
  localparam int btb_entries = 64;
  localparam int btb_index_w = 6;
  localparam int btb_tag_w = 25;

  typedef struct packed {
    logic [btb_tag_w-1:0] tag;
    logic [31:0]          target;
    logic [1:0]           sat;
  } btb_entry_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] taddr;
    logic [1:0]  tsat;
  } pred_t;

  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] pc1;
  } fetch_req_t;

  // The jump bit is the resolved direction, the pred field is what fetch predicted.
  typedef struct packed {
    logic        jal;
    logic        branch;
    logic        jump;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] npc;
    pred_t       pred;
  } resolve_req_t;

  typedef struct packed {
    logic                   wen;
    logic [btb_index_w-1:0] waddr;
    btb_entry_t             wdata;
  } btb_write_t;

  typedef struct packed {
    logic                   wreq;
    logic [btb_index_w-1:0] widx;
    btb_entry_t             wentry;
    logic                   miss;
    logic [31:0]            maddr;
  } slot_result_t;

  typedef struct packed {
    logic        miss;
    logic [31:0] maddr;
  } redirect_t;

  typedef enum logic [2:0] {
    outcome_none,
    outcome_correct,
    outcome_wrong_target,
    outcome_false_taken,
    outcome_missed_taken
  } outcome_e;

endpackage

/* source/btb_ram.sv */
`timescale 1ns/1ns

module btb_ram
  import btac_pkg::*;
(
  input  logic                   clock,
  input  logic [btb_index_w-1:0] raddr0_i,
  input  logic [btb_index_w-1:0] raddr1_i,
  input  btb_write_t             write_i,
  output btb_entry_t             rdata0_o,
  output btb_entry_t             rdata1_o
);

  // Contents start at zero and survive reset.
  btb_entry_t mem [btb_entries] = '{default: '0};

  logic [btb_index_w-1:0] raddr0_q = '0;
  logic [btb_index_w-1:0] raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0_i;
    raddr1_q <= raddr1_i;
    if (write_i.wen) begin
      mem[write_i.waddr] <= write_i.wdata;
    end
  end

  // The array is read through the registered addresses, so a write at the same
  // edge is already visible in the next cycle.
  assign rdata0_o = mem[raddr0_q];
  assign rdata1_o = mem[raddr1_q];

endmodule

/* source/btac_lookup.sv */
`timescale 1ns/1ns

module btac_lookup
  import btac_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear_i,
  input  logic                   stall_i,
  input  fetch_req_t             fetch_i,
  output logic [btb_index_w-1:0] raddr0_o,
  output logic [btb_index_w-1:0] raddr1_o,
  input  btb_entry_t             rdata0_i,
  input  btb_entry_t             rdata1_i,
  output pred_t                  pred0_o,
  output pred_t                  pred1_o
);

  fetch_req_t pc_q;
  logic       blank;

  // A hit needs the full tag to match and the counter to lean towards taken.
  function automatic pred_t predict(btb_entry_t entry, logic [31:0] pc);
    pred_t p;
    p.taken = (entry.tag == pc[31:btb_index_w+1]) && entry.sat[1];
    p.taddr = entry.target;
    p.tsat = entry.sat;
    return p;
  endfunction

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= '0;
    end else if (!clear_i) begin
      pc_q <= fetch_i;
    end
  end

  // While cleared, the buffer keeps reading the held PCs so its address
  // register stays in step with pc_q.
  assign raddr0_o = clear_i ? pc_q.pc0[btb_index_w:1] : fetch_i.pc0[btb_index_w:1];
  assign raddr1_o = clear_i ? pc_q.pc1[btb_index_w:1] : fetch_i.pc1[btb_index_w:1];

  assign blank = stall_i || clear_i;

  assign pred0_o = blank ? '0 : predict(rdata0_i, pc_q.pc0);
  assign pred1_o = blank ? '0 : predict(rdata1_i, pc_q.pc1);

endmodule

/* source/btac_resolve_slot.sv */
`timescale 1ns/1ns

module btac_resolve_slot
  import btac_pkg::*;
(
  input  resolve_req_t req_i,
  input  logic         clear_i,
  output slot_result_t result_o
);

  outcome_e   outcome;
  logic [1:0] new_sat;
  logic       taken_write;

  always_comb begin
    outcome = outcome_none;
    if (req_i.pred.taken) begin
      if (req_i.jump) begin
        if (req_i.addr != req_i.pred.taddr) begin
          outcome = outcome_wrong_target;
        end else begin
          outcome = outcome_correct;
        end
      end else if (req_i.branch) begin
        outcome = outcome_false_taken;
      end
    end else if (req_i.jump) begin
      outcome = outcome_missed_taken;
    end
  end

  // The two-bit saturating counter moves with the resolved direction.
  always_comb begin
    if (req_i.jump) begin
      new_sat = (&req_i.pred.tsat) ? req_i.pred.tsat : req_i.pred.tsat + 2'd1;
    end else begin
      new_sat = (|req_i.pred.tsat) ? req_i.pred.tsat - 2'd1 : req_i.pred.tsat;
    end
  end

  assign taken_write = (req_i.jal || req_i.branch) && req_i.jump;

  always_comb begin
    result_o = '0;
    result_o.widx = req_i.pc[btb_index_w:1];
    result_o.wentry.tag = req_i.pc[31:btb_index_w+1];
    result_o.wentry.target = req_i.jump ? req_i.addr : req_i.pred.taddr;
    result_o.wentry.sat = new_sat;
    if (!clear_i) begin
      // A wrongly predicted branch is written back too, so its counter can fall.
      result_o.wreq = taken_write || (outcome == outcome_false_taken);
      case (outcome)
        outcome_wrong_target, outcome_missed_taken: begin
          result_o.miss = 1'b1;
          result_o.maddr = req_i.addr;
        end
        outcome_false_taken: begin
          result_o.miss = 1'b1;
          result_o.maddr = req_i.npc;
        end
        default: begin
          result_o.miss = 1'b0;
          result_o.maddr = '0;
        end
      endcase
    end
  end

endmodule

/* source/btac_update_merge.sv */
`timescale 1ns/1ns

module btac_update_merge
  import btac_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  slot_result_t result0_i,
  input  slot_result_t result1_i,
  output btb_write_t   write_o,
  output logic         hazard0_o,
  output logic         hazard1_o,
  output redirect_t    redirect_o
);

  redirect_t redirect_q;

  // The buffer has one write port, so slot 0 takes it whenever it asks.
  assign write_o.wen = result0_i.wreq || result1_i.wreq;
  assign write_o.waddr = result0_i.wreq ? result0_i.widx : result1_i.widx;
  assign write_o.wdata = result0_i.wreq ? result0_i.wentry : result1_i.wentry;

  assign hazard0_o = result0_i.miss;
  assign hazard1_o = result1_i.miss;

  always_ff @(posedge clock) begin
    if (!reset) begin
      redirect_q.miss <= 1'b0;
    end else begin
      redirect_q.miss <= result0_i.miss || result1_i.miss;
    end
  end

  // The older instruction in slot 0 decides where fetch restarts.
  always_ff @(posedge clock) begin
    redirect_q.maddr <= result0_i.miss ? result0_i.maddr : result1_i.maddr;
  end

  assign redirect_o = redirect_q;

endmodule

/* source/btac.sv */
`timescale 1ns/1ns

module btac
  import btac_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         clear_i,
  input  logic         stall_i,
  input  fetch_req_t   fetch_i,
  input  resolve_req_t resolve0_i,
  input  resolve_req_t resolve1_i,
  output pred_t        pred0_o,
  output pred_t        pred1_o,
  output logic         hazard0_o,
  output logic         hazard1_o,
  output redirect_t    redirect_o
);

  logic [btb_index_w-1:0] raddr0;
  logic [btb_index_w-1:0] raddr1;
  btb_entry_t             rdata0;
  btb_entry_t             rdata1;
  btb_write_t             btb_write;
  slot_result_t           result0;
  slot_result_t           result1;

  btb_ram u_btb_ram (
    .clock    (clock),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .write_i  (btb_write),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1)
  );

  btac_lookup u_lookup (
    .clock    (clock),
    .reset    (reset),
    .clear_i  (clear_i),
    .stall_i  (stall_i),
    .fetch_i  (fetch_i),
    .raddr0_o (raddr0),
    .raddr1_o (raddr1),
    .rdata0_i (rdata0),
    .rdata1_i (rdata1),
    .pred0_o  (pred0_o),
    .pred1_o  (pred1_o)
  );

  btac_resolve_slot u_slot0 (
    .req_i    (resolve0_i),
    .clear_i  (clear_i),
    .result_o (result0)
  );

  btac_resolve_slot u_slot1 (
    .req_i    (resolve1_i),
    .clear_i  (clear_i),
    .result_o (result1)
  );

  btac_update_merge u_merge (
    .clock      (clock),
    .reset      (reset),
    .result0_i  (result0),
    .result1_i  (result1),
    .write_o    (btb_write),
    .hazard0_o  (hazard0_o),
    .hazard1_o  (hazard1_o),
    .redirect_o (redirect_o)
  );

endmodule

/* sim/btac_chk.sv */
`timescale 1ns/1ns

module btac_chk
  import btac_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input logic       clear_i,
  input logic       stall_i,
  input pred_t      pred0_o,
  input pred_t      pred1_o,
  input logic       hazard0_o,
  input logic       hazard1_o,
  input redirect_t  redirect_o,
  input btb_write_t btb_write
);

  assert property (@(posedge clock) !reset |=> !redirect_o.miss)
    else $error("redirect_o.miss set in the cycle after reset");

  // A redirect only follows a slot that raised a hazard.
  assert property (@(posedge clock) disable iff (!reset)
                   redirect_o.miss |-> $past(hazard0_o || hazard1_o))
    else $error("redirect_o.miss without a hazard in the previous cycle");

  assert property (@(posedge clock) clear_i |-> !btb_write.wen)
    else $error("buffer write enabled while clear_i is high");

  assert property (@(posedge clock) stall_i |-> ({pred0_o, pred1_o} == '0))
    else $error("prediction not blanked while stall_i is high");

endmodule

bind btac btac_chk u_chk (
  .clock      (clock),
  .reset      (reset),
  .clear_i    (clear_i),
  .stall_i    (stall_i),
  .pred0_o    (pred0_o),
  .pred1_o    (pred1_o),
  .hazard0_o  (hazard0_o),
  .hazard1_o  (hazard1_o),
  .redirect_o (redirect_o),
  .btb_write  (btb_write)
);

/* sim/btac_tb.sv */
`timescale 1ns/1ns

module btac_tb
  import btac_pkg::*;
();

  logic         clock;
  logic         reset;
  logic         clear_i;
  logic         stall_i;
  fetch_req_t   fetch_i;
  resolve_req_t resolve0_i;
  resolve_req_t resolve1_i;
  pred_t        pred0_o;
  pred_t        pred1_o;
  logic         hazard0_o;
  logic         hazard1_o;
  redirect_t    redirect_o;

  // Reference copy of the buffer, the registered lookup PCs and the registered redirect.
  btb_entry_t   model_mem [btb_entries] = '{default: '0};
  fetch_req_t   model_pc = '0;
  logic         exp_miss = 1'b0;
  logic [31:0]  exp_maddr = '0;
  integer       seed = 32'he449be3e;
  int           errors = 0;
  int           mark = 0;
  int           checks = 0;
  int           passed = 0;
  int           failed = 0;
  int           n;
  fetch_req_t   f;
  resolve_req_t r0;
  resolve_req_t r1;
  resolve_req_t idle = '0;
  logic [31:0]  p;
  logic [31:0]  q;

  btac uut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == mark) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - mark);
    end
    mark = errors;
  endtask

  // The pool holds eight PCs on two indices, and each index is shared by four tags.
  function automatic logic [31:0] pick_pc(input logic [31:0] r);
    return {r[2:1], 23'h2aaaaa, r[0] ? 6'd5 : 6'd40, 1'b0};
  endfunction

  function automatic pred_t model_predict(input logic [31:0] pc);
    pred_t pr;
    pr.taken = (model_mem[pc[6:1]].tag == pc[31:7]) && (model_mem[pc[6:1]].sat >= 2'd2);
    pr.taddr = model_mem[pc[6:1]].target;
    pr.tsat = model_mem[pc[6:1]].sat;
    return pr;
  endfunction

  task automatic model_slot(input resolve_req_t r, input logic cl, output logic miss,
                            output logic [31:0] maddr, output logic wreq);
    miss = 1'b0;
    maddr = '0;
    wreq = 1'b0;
    // Wrong target and missed taken both restart at the resolved target.
    if (!cl && r.jump && (!r.pred.taken || r.addr != r.pred.taddr)) begin
      miss = 1'b1;
      maddr = r.addr;
    end
    if (!cl && r.pred.taken && r.branch && !r.jump) begin
      miss = 1'b1;
      maddr = r.npc;
      wreq = 1'b1;
    end
    if (!cl && r.jump && (r.jal || r.branch)) begin
      wreq = 1'b1;
    end
  endtask

  function automatic btb_entry_t new_entry(input resolve_req_t r);
    btb_entry_t e;
    e.tag = r.pc[31:7];
    e.target = r.jump ? r.addr : r.pred.taddr;
    if (r.jump) begin
      e.sat = (r.pred.tsat == 2'd3) ? 2'd3 : r.pred.tsat + 2'd1;
    end else begin
      e.sat = (r.pred.tsat == 2'd0) ? 2'd0 : r.pred.tsat - 2'd1;
    end
    return e;
  endfunction

  function automatic resolve_req_t jal_req(input logic [31:0] pc, input logic [31:0] addr);
    resolve_req_t r;
    r = '0;
    r.pc = pc;
    r.npc = pc + 32'd4;
    r.addr = addr;
    r.jal = 1'b1;
    r.jump = 1'b1;
    r.pred = model_predict(pc);
    return r;
  endfunction

  // Most reports carry the prediction that the model would have made.
  task automatic random_resolve(output resolve_req_t r);
    logic [31:0] x;
    x = $random(seed);
    r = '0;
    r.pc = pick_pc(x);
    r.npc = r.pc + 32'd4;
    r.addr = {24'h000100, x[4:3], 6'h00};
    r.jal = (x[6:5] == 2'd0);
    r.branch = (x[6:5] == 2'd1);
    r.jump = r.jal || (x[6:5] == 2'd2) || (r.branch && x[7]);
    r.pred = model_predict(r.pc);
    if (x[9:8] == 2'd0) begin
      r.pred = {x[10], 24'h000100, x[12:11], 6'h00, x[14:13]};
    end
  endtask

  // Drive on the rising edge, check at the falling edge, then advance the model.
  task automatic run_cycle(input fetch_req_t fr, input resolve_req_t a, input resolve_req_t b,
                           input logic st, input logic cl);
    logic        miss0;
    logic        miss1;
    logic        wreq0;
    logic        wreq1;
    logic [31:0] maddr0;
    logic [31:0] maddr1;
    pred_t       exp0;
    pred_t       exp1;
    @(posedge clock);
    fetch_i <= fr;
    resolve0_i <= a;
    resolve1_i <= b;
    stall_i <= st;
    clear_i <= cl;
    @(negedge clock);
    exp0 = '0;
    exp1 = '0;
    if (!(st || cl)) begin
      exp0 = model_predict(model_pc.pc0);
      exp1 = model_predict(model_pc.pc1);
    end
    check_value("pred0_o", 64'(pred0_o), 64'(exp0));
    check_value("pred1_o", 64'(pred1_o), 64'(exp1));
    check_value("redirect_o.miss", 64'(redirect_o.miss), 64'(exp_miss));
    if (exp_miss) begin
      check_value("redirect_o.maddr", 64'(redirect_o.maddr), 64'(exp_maddr));
    end
    model_slot(a, cl, miss0, maddr0, wreq0);
    model_slot(b, cl, miss1, maddr1, wreq1);
    check_value("hazard0_o", 64'(hazard0_o), 64'(miss0));
    check_value("hazard1_o", 64'(hazard1_o), 64'(miss1));
    if (wreq0) begin
      model_mem[a.pc[6:1]] = new_entry(a);
    end else if (wreq1) begin
      model_mem[b.pc[6:1]] = new_entry(b);
    end
    if (!cl) begin
      model_pc = fr;
    end
    exp_miss = miss0 || miss1;
    exp_maddr = miss0 ? maddr0 : maddr1;
  endtask

  initial begin
    reset <= 1'b0;
    clear_i <= 1'b0;
    stall_i <= 1'b0;
    fetch_i <= '0;
    resolve0_i <= '0;
    resolve1_i <= '0;
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);

    n = 0;
    while (redirect_o.miss !== 1'b0 && n < 4) begin
      @(negedge clock);
      n++;
    end
    checks++;
    if (redirect_o.miss !== 1'b0) begin
      errors++;
      $display("Timed out waiting for redirect_o.miss to clear after reset.");
    end
    end_test("reset");

    // Five taken jumps climb to 3, then falsely predicted branches walk down to 0.
    p = pick_pc(32'd0);
    f.pc0 = p;
    f.pc1 = p;
    for (int i = 0; i < 12; i++) begin
      r0 = jal_req(p, 32'h00001040);
      if (i >= 5) begin
        r0.jal = 1'b0;
        r0.jump = 1'b0;
        r0.branch = 1'b1;
        r0.pred.taken = r0.pred.taken || (i >= 8);
      end
      run_cycle(f, r0, idle, 1'b0, 1'b0);
      if (i == 5) begin
        check_value("pred0_o.tsat", 64'(pred0_o.tsat), 64'd3);
      end
    end
    run_cycle(f, idle, idle, 1'b0, 1'b0);
    check_value("pred0_o.tsat", 64'(pred0_o.tsat), 64'd0);
    end_test("saturation");

    p = pick_pc(32'd3);
    q = pick_pc(32'd6);
    f.pc0 = p;
    f.pc1 = q;
    run_cycle(f, jal_req(p, 32'h00002000), jal_req(q, 32'h00003000), 1'b0, 1'b0);
    run_cycle(f, idle, idle, 1'b0, 1'b0);
    check_value("pred0_o.taddr", 64'(pred0_o.taddr), 64'h2000);
    checks++;
    if (pred1_o.taddr === 32'h00003000) begin
      errors++;
      $display("Slot 1 write reached the buffer although slot 0 wrote in the same cycle.");
    end
    end_test("write_conflict");

    for (int i = 0; i < 600; i++) begin
      f.pc0 = pick_pc($random(seed));
      f.pc1 = pick_pc($random(seed));
      random_resolve(r0);
      random_resolve(r1);
      if (i < 300) begin
        run_cycle(f, r0, r1, 1'b0, 1'b0);
      end else begin
        run_cycle(f, r0, r1, ($random(seed) & 7) == 0, ($random(seed) & 7) == 1);
      end
      if (i == 299) begin
        end_test("random");
      end
    end
    end_test("stall_clear");

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             passed, failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* all.f */
source/btac_pkg.sv
source/btb_ram.sv
source/btac_lookup.sv
source/btac_resolve_slot.sv
source/btac_update_merge.sv
source/btac.sv
sim/btac_chk.sv
sim/btac_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= btac_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
